// File: hdl/periph_bus_pkg.sv
`default_nettype none

// Widths and word types of the peripheral memory bus
package periph_bus_pkg;

	localparam int addr_w = 14;	// 16K words
	localparam int data_w = 16;

	// Word address into the peripheral memory
	typedef logic [addr_w-1:0] mem_addr_t;

	typedef logic [data_w-1:0] mem_data_t;

	// One enable per byte, bit 0 is the low byte
	typedef logic [data_w/8-1:0] wr_mask_t;

endpackage

`default_nettype wire

// File: hdl/periph_arb_pkg.sv
`default_nettype none

package periph_arb_pkg;

	// Arbiter state, doubles as the read return select
	typedef enum logic [1:0] {
		grant_cpu    = 2'd0,	// Idle state, CPU owns the memory
		grant_flash  = 2'd1,
		grant_bg0    = 2'd2,
		grant_sprite = 2'd3
	} grant_t;

endpackage

`default_nettype wire

// File: hdl/periph_axil_port.sv
`default_nettype none

module periph_axil_port
	import periph_bus_pkg::*, periph_arb_pkg::*;
#(
	parameter int AXI_ADDR_W = 16
) (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic [AXI_ADDR_W-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire mem_data_t wdata,
	input wire wr_mask_t wstrb,
	input wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic [AXI_ADDR_W-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output mem_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire logic rready,
	input wire grant_t grant,
	input wire mem_data_t ram_rdata,
	input wire logic cpu_rd_done,
	output logic cpu_req,
	output mem_addr_t cpu_addr,
	output mem_data_t cpu_wdata,
	output logic cpu_wr,
	output wr_mask_t cpu_wr_mask
);

	localparam logic [1:0] resp_okay = 2'b00;

	logic aw_pend;	// Write address held
	logic w_pend;	// Write data held
	logic ar_pend;	// Read waiting for a grant
	logic rd_wait;	// Read issued, data not back yet
	mem_addr_t aw_addr_r;
	mem_addr_t ar_addr_r;
	mem_data_t wdata_r;
	wr_mask_t wstrb_r;
	logic wr_go;
	logic rd_go;
	logic rd_back;

	// No new writes until the response has gone out
	assign awready = !aw_pend && !bvalid;
	assign wready = !w_pend && !bvalid;
	assign arready = !ar_pend && !rd_wait && !rvalid;

	assign bresp = resp_okay;
	assign rresp = resp_okay;

	// A complete write wins over a pending read
	assign cpu_wr = aw_pend && w_pend;
	assign cpu_req = cpu_wr || ar_pend;
	assign cpu_addr = cpu_wr ? aw_addr_r : ar_addr_r;
	assign cpu_wdata = wdata_r;
	assign cpu_wr_mask = wstrb_r;

	assign wr_go = cpu_wr && (grant == grant_cpu);
	assign rd_go = ar_pend && !cpu_wr && (grant == grant_cpu);
	assign rd_back = rd_wait && cpu_rd_done;

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
			ar_pend <= 1'b0;
			rd_wait <= 1'b0;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			if (awvalid && awready)
				aw_pend <= 1'b1;
			else if (wr_go)
				aw_pend <= 1'b0;

			if (wvalid && wready)
				w_pend <= 1'b1;
			else if (wr_go)
				w_pend <= 1'b0;

			if (wr_go)
				bvalid <= 1'b1;	// Write lands on this edge
			else if (bready)
				bvalid <= 1'b0;

			if (arvalid && arready)
				ar_pend <= 1'b1;
			else if (rd_go)
				ar_pend <= 1'b0;

			if (rd_go)
				rd_wait <= 1'b1;
			else if (cpu_rd_done)
				rd_wait <= 1'b0;

			if (rd_back)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge CLK) begin
		if (awvalid && awready)
			aw_addr_r <= awaddr[addr_w:1];	// Byte to word address
		if (wvalid && wready) begin
			wdata_r <= wdata;
			wstrb_r <= wstrb;
		end
		if (arvalid && arready)
			ar_addr_r <= araddr[addr_w:1];
		if (rd_back)
			rdata <= ram_rdata;
	end

	// Responses hold until the master takes them
	assert property (@(posedge CLK) disable iff (!RSTb)
		bvalid && !bready |=> bvalid);
	assert property (@(posedge CLK) disable iff (!RSTb)
		rvalid && !rready |=> rvalid && $stable(rdata));

	// A request passed over by the arbiter is presented again unchanged
	assert property (@(posedge CLK) disable iff (!RSTb)
		cpu_req && (grant != grant_cpu) |=>
			cpu_req && ($past(cpu_wr) ? (cpu_wr && $stable(cpu_addr)
			&& $stable(cpu_wdata) && $stable(cpu_wr_mask)) : 1'b1));

endmodule

`default_nettype wire

// File: hdl/periph_memory_arbiter.sv
`default_nettype none

module periph_memory_arbiter
	import periph_bus_pkg::*, periph_arb_pkg::*;
(
	input wire logic CLK,
	input wire logic RSTb,
	output grant_t grant,
	output mem_addr_t ram_addr,
	output mem_data_t ram_din,
	output logic ram_wr,
	output wr_mask_t ram_wr_mask,
	input wire logic sprite_valid,
	input wire mem_addr_t sprite_addr,
	input wire logic bg0_valid,
	input wire mem_addr_t bg0_addr,
	input wire logic fl_valid,
	input wire mem_addr_t fl_addr,
	input wire mem_data_t fl_data,
	input wire logic cpu_req,
	input wire mem_addr_t cpu_addr,
	input wire mem_data_t cpu_wdata,
	input wire logic cpu_wr,
	input wire wr_mask_t cpu_wr_mask
);

	grant_t state;
	logic held;	// Current owner still wants the memory

	assign grant = state;

	always_comb begin
		case (state)
			grant_sprite: held = sprite_valid;
			grant_bg0:    held = bg0_valid;
			grant_flash:  held = fl_valid;
			default:      held = 1'b0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			state <= grant_cpu;
		else if (state == grant_cpu) begin
			if (sprite_valid)
				state <= grant_sprite;
			else if (bg0_valid)
				state <= grant_bg0;
			else if (fl_valid)
				state <= grant_flash;
		end else if (!held)
			state <= grant_cpu;	// Back to idle, CPU gets the slot
	end

	// Access mux follows the state directly
	always_comb begin
		ram_din = cpu_wdata;
		ram_wr_mask = '0;
		ram_wr = 1'b0;
		case (state)
			grant_cpu: begin
				ram_addr = cpu_addr;
				ram_wr = cpu_req && cpu_wr;
				ram_wr_mask = cpu_wr_mask;
			end
			grant_flash: begin
				ram_addr = fl_addr;
				ram_din = fl_data;
				ram_wr = 1'b1;
				ram_wr_mask = '1;	// Flash always writes whole words
			end
			grant_bg0:
				ram_addr = bg0_addr;
			default:
				ram_addr = sprite_addr;
		endcase
	end

	assert property (@(posedge CLK) disable iff (!RSTb)
		(((state == grant_sprite) && sprite_valid) || ((state == grant_bg0) && bg0_valid)
		|| ((state == grant_flash) && fl_valid)) |=> $stable(state));

endmodule

`default_nettype wire

// File: hdl/periph_ram.sv
`default_nettype none

module periph_ram
	import periph_bus_pkg::*;
#(
	parameter int MEM_DEPTH = 16384
) (
	input wire logic CLK,
	input wire mem_addr_t addr,
	input wire mem_data_t din,
	input wire logic wr,
	input wire wr_mask_t wr_mask,
	output mem_data_t dout
);

	localparam int idx_w = $clog2(MEM_DEPTH);

	mem_data_t mem [MEM_DEPTH];
	logic [idx_w-1:0] idx;

	// Upper address bits drop out for a short memory
	assign idx = addr[idx_w-1:0];

	always_ff @(posedge CLK) begin
		if (wr) begin
			for (int b = 0; b < $bits(wr_mask_t); b++) begin
				if (wr_mask[b])
					mem[idx][b*8 +: 8] <= din[b*8 +: 8];
			end
		end
		dout <= mem[idx];	// Old word on a write cycle
	end

endmodule

`default_nettype wire

// File: hdl/periph_read_return.sv
`default_nettype none

module periph_read_return
	import periph_bus_pkg::*, periph_arb_pkg::*;
(
	input wire logic CLK,
	input wire logic RSTb,
	input wire grant_t grant,
	input wire logic ram_wr,
	input wire logic cpu_req,
	input wire mem_data_t ram_dout,
	output logic cpu_rd_done,
	output mem_data_t bg0_rdata,
	output logic bg0_rvalid,
	output mem_data_t sprite_rdata,
	output logic sprite_rvalid
);

	grant_t grant_q;	// Who owned the last access edge
	logic rd_q;
	logic rd_now;

	// An idle CPU slot is not a read
	assign rd_now = !ram_wr && ((grant != grant_cpu) || cpu_req);

	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			grant_q <= grant_cpu;
			rd_q <= 1'b0;
		end else begin
			grant_q <= grant;
			rd_q <= rd_now;
		end
	end

	// RAM output is valid in this cycle, one pulse per access
	assign cpu_rd_done = rd_q && (grant_q == grant_cpu);
	assign bg0_rvalid = rd_q && (grant_q == grant_bg0);
	assign sprite_rvalid = rd_q && (grant_q == grant_sprite);

	assign bg0_rdata = ram_dout;
	assign sprite_rdata = ram_dout;

	// One strobe at most
	assert property (@(posedge CLK) disable iff (!RSTb)
		$onehot0({cpu_rd_done, bg0_rvalid, sprite_rvalid}));

	// Background and sprite slots never write
	assert property (@(posedge CLK) disable iff (!RSTb)
		((grant == grant_bg0) || (grant == grant_sprite)) |-> !ram_wr);

endmodule

`default_nettype wire

// File: hdl/periph_mem_top.sv
`default_nettype none

module periph_mem_top
	import periph_bus_pkg::*, periph_arb_pkg::*;
#(
	parameter int MEM_DEPTH = 16384,
	parameter int AXI_ADDR_W = 16
) (
	input wire logic CLK,
	input wire logic RSTb,
	input wire logic [AXI_ADDR_W-1:0] awaddr,
	input wire logic awvalid,
	output logic awready,
	input wire mem_data_t wdata,
	input wire wr_mask_t wstrb,
	input wire logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input wire logic bready,
	input wire logic [AXI_ADDR_W-1:0] araddr,
	input wire logic arvalid,
	output logic arready,
	output mem_data_t rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input wire logic rready,
	input wire logic sprite_valid,
	input wire mem_addr_t sprite_addr,
	input wire logic bg0_valid,
	input wire mem_addr_t bg0_addr,
	input wire logic fl_valid,
	input wire mem_addr_t fl_addr,
	input wire mem_data_t fl_data,
	output mem_data_t bg0_rdata,
	output logic bg0_rvalid,
	output mem_data_t sprite_rdata,
	output logic sprite_rvalid,
	output grant_t grant
);

	logic cpu_req;
	mem_addr_t cpu_addr;
	mem_data_t cpu_wdata;
	logic cpu_wr;
	wr_mask_t cpu_wr_mask;
	logic cpu_rd_done;
	mem_addr_t ram_addr;
	mem_data_t ram_din;
	mem_data_t ram_dout;
	logic ram_wr;
	wr_mask_t ram_wr_mask;

	// CPU side, AXI to memory requests
	periph_axil_port #(.AXI_ADDR_W(AXI_ADDR_W)) u_port (
		.CLK, .RSTb,
		.awaddr, .awvalid, .awready,
		.wdata, .wstrb, .wvalid, .wready,
		.bresp, .bvalid, .bready,
		.araddr, .arvalid, .arready,
		.rdata, .rresp, .rvalid, .rready,
		.grant, .ram_rdata(ram_dout), .cpu_rd_done,
		.cpu_req, .cpu_addr, .cpu_wdata, .cpu_wr, .cpu_wr_mask
	);

	periph_memory_arbiter u_arb (
		.CLK, .RSTb, .grant,
		.ram_addr, .ram_din, .ram_wr, .ram_wr_mask,
		.sprite_valid, .sprite_addr, .bg0_valid, .bg0_addr,
		.fl_valid, .fl_addr, .fl_data,
		.cpu_req, .cpu_addr, .cpu_wdata, .cpu_wr, .cpu_wr_mask
	);

	periph_ram #(.MEM_DEPTH(MEM_DEPTH)) u_ram (
		.CLK, .addr(ram_addr), .din(ram_din),
		.wr(ram_wr), .wr_mask(ram_wr_mask), .dout(ram_dout)
	);

	// Read data back to whoever asked
	periph_read_return u_ret (
		.CLK, .RSTb, .grant, .ram_wr, .cpu_req, .ram_dout,
		.cpu_rd_done, .bg0_rdata, .bg0_rvalid, .sprite_rdata, .sprite_rvalid
	);

endmodule

`default_nettype wire

// File: tb/periph_mem_checker.sv
`default_nettype none

module periph_mem_checker
	import periph_arb_pkg::*;
#(
	parameter int WIN = 64
) (
	input wire logic CLK,
	input wire logic RSTb,
	input wire grant_t grant,
	input wire logic sprite_valid,
	input wire logic [13:0] sprite_addr,
	input wire logic bg0_valid,
	input wire logic [13:0] bg0_addr,
	input wire logic fl_valid,
	input wire logic awready,
	input wire logic wready,
	input wire logic arvalid,
	input wire logic arready,
	input wire logic [15:0] araddr,
	input wire logic [1:0] bresp,
	input wire logic bvalid,
	input wire logic bready,
	input wire logic [15:0] rdata,
	input wire logic [1:0] rresp,
	input wire logic rvalid,
	input wire logic rready,
	input wire logic [15:0] bg0_rdata,
	input wire logic bg0_rvalid,
	input wire logic [15:0] sprite_rdata,
	input wire logic sprite_rvalid,
	input logic [15:0] shadow [WIN],
	output int err_count,
	output int check_count
);

	timeunit 1ns;
	timeprecision 1ps;

	grant_t grant_exp;	// Arbiter model
	logic sp_exp, bg_exp;
	logic [15:0] sp_word, bg_word;
	logic [5:0] ar_q;
	logic rvalid_q, rready_q, bvalid_q, bready_q;
	logic [15:0] rdata_q;
	int rst_edges = 0;
	int errs = 0;
	int checks = 0;

	assign err_count = errs;
	assign check_count = checks;

	task automatic check_val(input string name, input logic [15:0] exp, input logic [15:0] act);
		checks++;
		if (act !== exp) begin
			errs++;
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
		end
	endtask

	// All checks use the values from just before the edge
	always @(posedge CLK) begin
		if (!RSTb) begin
			if (rst_edges > 0) begin
				check_val("grant", 16'(grant_cpu), 16'(grant));
				check_val("bvalid", 16'd0, {15'd0, bvalid});
				check_val("rvalid", 16'd0, {15'd0, rvalid});
				check_val("bg0_rvalid", 16'd0, {15'd0, bg0_rvalid});
				check_val("sprite_rvalid", 16'd0, {15'd0, sprite_rvalid});
				check_val("awready", 16'd1, {15'd0, awready});
				check_val("wready", 16'd1, {15'd0, wready});
				check_val("arready", 16'd1, {15'd0, arready});
			end
			rst_edges++;
			grant_exp <= grant_cpu;
			{sp_exp, bg_exp, rvalid_q, rready_q, bvalid_q, bready_q} <= '0;
		end else begin
			check_val("grant", 16'(grant_exp), 16'(grant));
			check_val("sprite_rvalid", {15'd0, sp_exp}, {15'd0, sprite_rvalid});
			check_val("bg0_rvalid", {15'd0, bg_exp}, {15'd0, bg0_rvalid});
			if (sp_exp)
				check_val("sprite_rdata", sp_word, sprite_rdata);
			if (bg_exp)
				check_val("bg0_rdata", bg_word, bg0_rdata);
			// Priority sprite, bg0, flash, owner held while its valid stays up
			if (grant_exp == grant_cpu)
				grant_exp <= sprite_valid ? grant_sprite : bg0_valid ? grant_bg0
					: fl_valid ? grant_flash : grant_cpu;
			else if ((grant_exp == grant_sprite && !sprite_valid)
					|| (grant_exp == grant_bg0 && !bg0_valid)
					|| (grant_exp == grant_flash && !fl_valid))
				grant_exp <= grant_cpu;
			sp_exp <= (grant_exp == grant_sprite);
			bg_exp <= (grant_exp == grant_bg0);
			sp_word <= shadow[sprite_addr[5:0]];
			bg_word <= shadow[bg0_addr[5:0]];
			if (arvalid && arready)
				ar_q <= araddr[6:1];
			if (rvalid && !rvalid_q) begin
				check_val("rdata", shadow[ar_q], rdata);
				check_val("rresp", 16'd0, {14'd0, rresp});
			end
			if (rvalid_q && !rready_q) begin	// Response held under back-pressure
				check_val("rvalid", 16'd1, {15'd0, rvalid});
				check_val("rdata", rdata_q, rdata);
			end
			if (bvalid && !bvalid_q)
				check_val("bresp", 16'd0, {14'd0, bresp});
			if (bvalid_q && !bready_q)
				check_val("bvalid", 16'd1, {15'd0, bvalid});
			rvalid_q <= rvalid;
			rready_q <= rready;
			rdata_q <= rdata;
			bvalid_q <= bvalid;
			bready_q <= bready;
		end
	end

endmodule

`default_nettype wire

// File: tb/tb_periph_mem.sv
`default_nettype none

module tb_periph_mem
	import periph_bus_pkg::*, periph_arb_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int n_trans = 300;
	localparam int wait_limit = 2000;	// Cycles allowed per wait loop
	localparam int win = 64;	// Test address window in words

	logic CLK, RSTb;
	logic [15:0] awaddr, araddr;
	logic awvalid, wvalid, bready, arvalid, rready;
	logic awready, wready, bvalid, arready, rvalid;
	logic [1:0] bresp, rresp;
	mem_data_t wdata, rdata, fl_data, bg0_rdata, sprite_rdata;
	wr_mask_t wstrb;
	logic sprite_valid, bg0_valid, fl_valid, bg0_rvalid, sprite_rvalid;
	mem_addr_t sprite_addr, bg0_addr, fl_addr;
	grant_t grant;

	mem_data_t shadow [win];
	logic [31:0] lfsr;
	logic bvalid_seen;
	mem_addr_t wr_addr_q;	// Write in flight on the CPU side
	mem_data_t wr_data_q;
	wr_mask_t wr_strb_q;
	int err_count, check_count;

	periph_mem_top #(.MEM_DEPTH(16384), .AXI_ADDR_W(16)) dut (.*);

	periph_mem_checker #(.WIN(win)) u_chk (.*);

	initial begin
		CLK = 1'b0;
		forever #20 CLK = ~CLK;
	end

	// One bit per LFSR step
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// Shadow memory follows every write into the RAM
	always @(negedge CLK) begin
		if (bvalid && !bvalid_seen) begin
			if (wr_strb_q[0])
				shadow[wr_addr_q[5:0]][7:0] = wr_data_q[7:0];
			if (wr_strb_q[1])
				shadow[wr_addr_q[5:0]][15:8] = wr_data_q[15:8];
		end
		bvalid_seen = bvalid;
		if (RSTb && grant == grant_flash)
			shadow[fl_addr[5:0]] = fl_data;	// Written on the coming edge
	end

	task automatic abort_on_timeout(input string what);
		$display("Timeout while waiting for %s at %0t", what, $time);
		$display("Errors: %0d in %0d checks", err_count, check_count);
		$display("Test failed");
		$finish;
	endtask

	task automatic cpu_write(input mem_addr_t addr, input mem_data_t data, input wr_mask_t strb);
		logic [31:0] r;
		bit aw_done, w_done;
		int n;
		r = take_bits(1);
		wr_addr_q = addr;
		wr_data_q = data;
		wr_strb_q = strb;
		@(posedge CLK);
		awaddr <= {1'b0, addr, 1'b0};
		awvalid <= 1'b1;
		wdata <= data;
		wstrb <= strb;
		wvalid <= !r[0];	// Data together with the address or after it
		aw_done = 1'b0;
		w_done = 1'b0;
		n = 0;
		while (!(aw_done && w_done)) begin
			@(posedge CLK);
			if (awvalid && awready) begin
				aw_done = 1'b1;
				awvalid <= 1'b0;
			end
			if (wvalid && wready) begin
				w_done = 1'b1;
				wvalid <= 1'b0;
			end else if (aw_done)
				wvalid <= 1'b1;
			n++;
			if (n == wait_limit)
				abort_on_timeout("write address and data handshake");
		end
		n = 0;
		do begin
			@(posedge CLK);
			n++;
			if (n == wait_limit)
				abort_on_timeout("bvalid");
		end while (!bvalid);
		r = take_bits(2);
		repeat (r[1:0]) @(posedge CLK);	// Hold off the response
		bready <= 1'b1;
		@(posedge CLK);
		bready <= 1'b0;
	endtask

	task automatic cpu_read(input mem_addr_t addr);
		logic [31:0] r;
		int n;
		@(posedge CLK);
		araddr <= {1'b0, addr, 1'b0};
		arvalid <= 1'b1;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
			if (n == wait_limit)
				abort_on_timeout("arready");
		end while (!arready);
		arvalid <= 1'b0;
		n = 0;
		do begin
			@(posedge CLK);
			n++;
			if (n == wait_limit)
				abort_on_timeout("rvalid");
		end while (!rvalid);
		r = take_bits(2);
		repeat (r[1:0]) @(posedge CLK);
		rready <= 1'b1;
		@(posedge CLK);
		rready <= 1'b0;
	endtask

	// Random subset of requesters, each valid for 1 to 8 cycles (or len_bg for bg0)
	task automatic run_requesters(input bit allow_flash, input int len_bg);
		logic [31:0] m, r;
		int len_sp, len_fl;
		m = take_bits(3);
		r = take_bits(3);
		len_sp = m[0] ? int'(r[2:0]) + 1 : 0;
		r = take_bits(3);
		len_fl = (m[2] && allow_flash) ? int'(r[2:0]) + 1 : 0;
		if (len_bg == 0 && m[1]) begin
			r = take_bits(3);
			len_bg = int'(r[2:0]) + 1;
		end
		for (int c = 0; c < 8 || c < len_bg; c++) begin
			@(posedge CLK);
			r = take_bits(18);
			sprite_valid <= (c < len_sp);
			bg0_valid <= (c < len_bg);
			fl_valid <= (c < len_fl);
			if (c < len_sp)
				sprite_addr <= {8'd0, r[5:0]};
			if (c < len_bg)
				bg0_addr <= {8'd0, r[11:6]};
			if (c < len_fl) begin
				fl_addr <= {8'd0, r[17:12]};
				fl_data <= mem_data_t'(take_bits(16));
			end
		end
		@(posedge CLK);
		sprite_valid <= 1'b0;
		bg0_valid <= 1'b0;
		fl_valid <= 1'b0;
	endtask

	initial begin
		logic [31:0] r;
		RSTb = 1'b0;
		{awvalid, wvalid, bready, arvalid, rready} = '0;
		{sprite_valid, bg0_valid, fl_valid} = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		wstrb = '0;
		sprite_addr = '0;
		bg0_addr = '0;
		fl_addr = '0;
		fl_data = '0;
		lfsr = 32'h2ede1be2;
		bvalid_seen = 1'b0;
		foreach (shadow[i])
			shadow[i] = '0;
		repeat (8) @(posedge CLK);
		RSTb <= 1'b1;
		// Fill the window through the flash path
		for (int i = 0; i < win + 2; i++) begin
			@(posedge CLK);
			fl_valid <= 1'b1;
			fl_addr <= mem_addr_t'(i % win);
			fl_data <= mem_data_t'(take_bits(16));
		end
		@(posedge CLK);
		fl_valid <= 1'b0;
		cpu_write(14'd5, 16'ha5c3, 2'b01);	// Low byte only
		cpu_read(14'd5);
		for (int t = 0; t < n_trans; t++) begin
			r = take_bits(26);
			if (r[25:24] == 2'd0)
				cpu_write({8'd0, r[5:0]}, r[21:6], (r[23:22] == 2'd0) ? 2'b11 : r[23:22]);
			else if (r[25:24] == 2'd1)
				fork
					cpu_write({8'd0, r[5:0]}, r[21:6], (r[23:22] == 2'd0) ? 2'b10 : r[23:22]);
					run_requesters(1'b1, 0);
				join
			else if (r[25:24] == 2'd2)
				cpu_read({8'd0, r[5:0]});
			else
				fork
					cpu_read({8'd0, r[5:0]});
					run_requesters(1'b0, 0);
				join
		end
		fork	// CPU read stuck behind a long background burst
			cpu_read(14'd5);
			run_requesters(1'b0, 40);
		join
		repeat (4) @(posedge CLK);
		$display("Errors: %0d in %0d checks", err_count, check_count);
		if (err_count == 0)
			$display("Test passed");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
hdl/periph_bus_pkg.sv
hdl/periph_arb_pkg.sv
hdl/periph_axil_port.sv
hdl/periph_memory_arbiter.sv
hdl/periph_ram.sv
hdl/periph_read_return.sv
hdl/periph_mem_top.sv
tb/periph_mem_checker.sv
tb/tb_periph_mem.sv

// File: Makefile
SRCS := $(shell cat filelist.f)

obj_dir/Vtb_periph_mem: filelist.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_periph_mem -f filelist.f

run: obj_dir/Vtb_periph_mem
	./obj_dir/Vtb_periph_mem | awk '{ print } /^Test passed$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

.PHONY: run clean
